// ==== source/spi_cmd_pkg.sv ====
package spi_cmd_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths of the command format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // flag, 3-bit address, 8 data bits
  typedef logic [11:0] cmd_word_t;
  typedef logic [2:0]  reg_addr_t;
  typedef logic [7:0]  read_byte_t;
  typedef logic [3:0]  bit_count_t;

  // one-cycle strobes marking sclk transitions
  typedef struct packed {
    logic sclk_rise;
    logic sclk_fall;
  } spi_edge_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_ADDR,
    ST_TURN,
    ST_READ,
    ST_DONE
  } ctrl_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame timing and lengths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int HALF_PERIOD = 4;
  // cs high between address and data phase
  localparam int TURN_CYCLES = 100;

  localparam bit_count_t WRITE_BITS = 4'd12;
  localparam bit_count_t ADDR_BITS  = 4'd4;
  localparam bit_count_t READ_BITS  = 4'd8;
  localparam int CMD_WRITE_BIT = 11;

endpackage

// ==== source/spi_sclk_gen.sv ====
`timescale 1ns/1ps

module spi_sclk_gen
  import spi_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      run,
  output logic      sclk,
  output spi_edge_t edges
);

  logic [$clog2(HALF_PERIOD)-1:0] half_cnt;
  logic                           half_end;

  assign half_end = (half_cnt == ($clog2(HALF_PERIOD))'(HALF_PERIOD - 1));

  // sclk idles low in mode 0 and the first toggle is a rise
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt <= '0;
      sclk     <= 1'b0;
      edges    <= '0;
    end
    else if (!run)
    begin
      // park between frames
      half_cnt <= '0;
      sclk     <= 1'b0;
      edges    <= '0;
    end
    else
    begin
      edges.sclk_rise <= half_end && !sclk;
      edges.sclk_fall <= half_end && sclk;
      if (half_end)
      begin
        half_cnt <= '0;
        sclk     <= ~sclk;
      end
      else
      begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== source/spi_tx_shifter.sv ====
`timescale 1ns/1ps

module spi_tx_shifter
  import spi_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      load,
  input  cmd_word_t cmd,
  input  logic      shift,
  output logic      mosi,
  output logic      tx_done
);

  cmd_word_t  tx_reg;
  bit_count_t bits_left;

  // bits still to go out after the one on mosi
  always_ff @(posedge clk)
  begin
    if (load)
      tx_reg <= cmd << 1;
    else if (shift)
      tx_reg <= tx_reg << 1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mosi      <= 1'b0;
      bits_left <= '0;
      tx_done   <= 1'b0;
    end
    else
    begin
      tx_done <= 1'b0;
      if (load)
      begin
        mosi      <= cmd[$bits(cmd_word_t)-1];
        // a read only sends flag and address
        bits_left <= cmd[CMD_WRITE_BIT] ? WRITE_BITS : ADDR_BITS;
      end
      else if (shift && bits_left != '0)
      begin
        bits_left <= bits_left - 1'b1;
        if (bits_left == 4'd1)
        begin
          mosi    <= 1'b0;
          tx_done <= 1'b1;
        end
        else
        begin
          mosi <= tx_reg[$bits(cmd_word_t)-1];
        end
      end
    end
  end

endmodule

// ==== source/spi_rx_shifter.sv ====
`timescale 1ns/1ps

module spi_rx_shifter
  import spi_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sample_en,
  input  logic       sclk_rise,
  input  logic       miso,
  output read_byte_t read_data,
  output logic       read_vld
);

  read_byte_t rx_reg;
  bit_count_t sample_cnt;
  logic       sample;
  logic       last_sample;

  assign sample      = sample_en && sclk_rise;
  assign last_sample = sample && (sample_cnt == READ_BITS - 1'b1);

  // msb arrives first
  always_ff @(posedge clk)
  begin
    if (sample)
      rx_reg <= {rx_reg[$bits(read_byte_t)-2:0], miso};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sample_cnt <= '0;
      read_data  <= '0;
      read_vld   <= 1'b0;
    end
    else
    begin
      read_vld <= last_sample;
      if (!sample_en || last_sample)
        sample_cnt <= '0;
      else if (sample)
        sample_cnt <= sample_cnt + 1'b1;
      if (last_sample)
        read_data <= {rx_reg[$bits(read_byte_t)-2:0], miso};
    end
  end

endmodule

// ==== source/spi_cmd_ctrl.sv ====
`timescale 1ns/1ps

module spi_cmd_ctrl
  import spi_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cmd_vld,
  output logic      cmd_rdy,
  input  cmd_word_t cmd_in,
  input  spi_edge_t edges,
  input  logic      tx_done,
  input  logic      read_vld,
  output logic      run,
  output logic      load,
  output logic      shift,
  output logic      sample_en,
  output logic      cs
);

  ctrl_state_e state;
  ctrl_state_e next_state;

  logic [$clog2(TURN_CYCLES)-1:0] turn_cnt;

  logic accept;
  logic turn_last;
  logic cur_active;
  logic next_active;
  logic frame_end;
  logic out_phase;

  assign accept    = cmd_vld && cmd_rdy;
  assign turn_last = (turn_cnt == ($clog2(TURN_CYCLES))'(TURN_CYCLES - 1));

  assign out_phase  = (state == ST_WRITE) || (state == ST_ADDR);
  assign cur_active = out_phase || (state == ST_READ);

  assign next_active = (next_state == ST_WRITE) || (next_state == ST_ADDR) ||
                       (next_state == ST_READ);

  // last cycle of a cs-low period
  assign frame_end = (out_phase && tx_done) || ((state == ST_READ) && read_vld);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    next_state = state;
    case (state)
      ST_IDLE:
      begin
        if (accept)
          next_state = cmd_in[CMD_WRITE_BIT] ? ST_WRITE : ST_ADDR;
      end
      ST_WRITE:
      begin
        if (tx_done)
          next_state = ST_DONE;
      end
      ST_ADDR:
      begin
        if (tx_done)
          next_state = ST_TURN;
      end
      ST_TURN:
      begin
        if (turn_last)
          next_state = ST_READ;
      end
      ST_READ:
      begin
        if (read_vld)
          next_state = ST_DONE;
      end
      ST_DONE:
      begin
        next_state = ST_IDLE;
      end
      default:
      begin
        next_state = ST_IDLE;
      end
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state, cs, cmd_rdy and turnaround
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      cs       <= 1'b1;
      cmd_rdy  <= 1'b1;
      turn_cnt <= '0;
    end
    else
    begin
      state <= next_state;
      cs    <= !next_active;
      if (accept)
        cmd_rdy <= 1'b0;
      else if (state == ST_DONE)
        cmd_rdy <= 1'b1;
      if (state == ST_TURN)
        turn_cnt <= turn_cnt + 1'b1;
      else
        turn_cnt <= '0;
    end
  end

  // sclk stops in the cycle the frame ends, so it is low once cs rises
  assign run       = cur_active && !frame_end;
  assign load      = accept;
  assign shift     = out_phase && edges.sclk_fall;
  assign sample_en = (state == ST_READ);

endmodule

// ==== source/spi_cmd_master.sv ====
`timescale 1ns/1ps

module spi_cmd_master
  import spi_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_word_t  cmd_in,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  output logic       sclk,
  output logic       cs,
  output logic       mosi,
  input  logic       miso,
  output logic       read_vld,
  output read_byte_t read_data
);

  spi_edge_t sclk_edges;
  logic      run;
  logic      load;
  logic      shift;
  logic      tx_done;
  logic      sample_en;

  spi_cmd_ctrl i_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .cmd_in    (cmd_in),
    .edges     (sclk_edges),
    .tx_done   (tx_done),
    .read_vld  (read_vld),
    .run       (run),
    .load      (load),
    .shift     (shift),
    .sample_en (sample_en),
    .cs        (cs)
  );

  spi_sclk_gen i_sclk_gen (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .sclk  (sclk),
    .edges (sclk_edges)
  );

  spi_tx_shifter i_tx_shifter (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (load),
    .cmd     (cmd_in),
    .shift   (shift),
    .mosi    (mosi),
    .tx_done (tx_done)
  );

  // read_vld also closes the read frame in the controller
  spi_rx_shifter i_rx_shifter (
    .clk       (clk),
    .rst_n     (rst_n),
    .sample_en (sample_en),
    .sclk_rise (sclk_edges.sclk_rise),
    .miso      (miso),
    .read_data (read_data),
    .read_vld  (read_vld)
  );

endmodule

// ==== verification/spi_periph_model.sv ====
`timescale 1ns/1ps

module spi_periph_model
  import spi_cmd_pkg::*;
(
  input  logic      sclk,
  input  logic      cs,
  input  logic      mosi,
  output logic      miso,
  output int        frame_cnt,
  output cmd_word_t last_cmd
);

  read_byte_t regs [8];
  cmd_word_t  rx_word;
  int         rx_bits;
  reg_addr_t  rd_addr;
  logic       rd_pending;
  logic       in_data;
  read_byte_t tx_byte;
  logic       cs_q;
  logic       sclk_q;

  initial
  begin
    reg_addr_t a;
    for (int r = 0; r < 8; r++)
    begin
      a       = reg_addr_t'(r);
      regs[a] = read_byte_t'(r * 8'h11) ^ 8'ha5;
    end
    miso       = 1'b0;
    frame_cnt  = 0;
    last_cmd   = '0;
    rx_word    = '0;
    rx_bits    = 0;
    rd_addr    = '0;
    rd_pending = 1'b0;
    in_data    = 1'b0;
    tx_byte    = '0;
    cs_q       = 1'b1;
    sclk_q     = 1'b0;
    forever
    begin
      @(sclk or cs);
      // cs low after an address frame is the data phase
      if (!cs && cs_q)
      begin
        rx_bits = 0;
        rx_word = '0;
        in_data = rd_pending;
        if (rd_pending)
        begin
          tx_byte = regs[rd_addr];
          miso    = tx_byte[7];
          tx_byte = tx_byte << 1;
        end
      end
      if (sclk && !sclk_q && !cs && !in_data)
      begin
        rx_word = {rx_word[10:0], mosi};
        rx_bits = rx_bits + 1;
      end
      // next bit after each falling edge in mode 0
      if (!sclk && sclk_q && in_data)
      begin
        miso    = tx_byte[7];
        tx_byte = tx_byte << 1;
      end
      if (cs && !cs_q)
      begin
        if (in_data)
        begin
          in_data    = 1'b0;
          rd_pending = 1'b0;
        end
        else if (rx_bits != 0)
        begin
          frame_cnt = frame_cnt + 1;
          if (rx_bits == 12 && rx_word[11])
          begin
            regs[rx_word[10:8]] = rx_word[7:0];
            last_cmd            = rx_word;
          end
          else if (rx_bits == 4 && !rx_word[3])
          begin
            rd_addr    = rx_word[2:0];
            rd_pending = 1'b1;
          end
        end
      end
      cs_q   = cs;
      sclk_q = sclk;
    end
  end

endmodule

// ==== verification/spi_cmd_assertions.sv ====
`timescale 1ns/1ps

module spi_cmd_assertions
  import spi_cmd_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        cs,
  input logic        cmd_rdy,
  input logic        run,
  input logic        read_vld,
  input ctrl_state_e state
);

  // no command taken while a frame is on the wire
  rdy_low_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
    !cs |-> !cmd_rdy)
    else $error("cmd_rdy high while cs is low");

  // sclk follows run one cycle late, so both must be off with cs high
  sclk_parked: assert property (@(posedge clk) disable iff (!rst_n)
    cs |-> (!run && !$past(run)))
    else $error("sclk running while cs is high");

  read_vld_in_read: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> (state == ST_READ))
    else $error("read_vld outside a read frame");

endmodule

bind spi_cmd_ctrl spi_cmd_assertions i_assertions (
  .clk      (clk),
  .rst_n    (rst_n),
  .cs       (cs),
  .cmd_rdy  (cmd_rdy),
  .run      (run),
  .read_vld (read_vld),
  .state    (state)
);

// ==== verification/tb_spi_cmd_master.sv ====
`timescale 1ns/1ps

module tb_spi_cmd_master
  import spi_cmd_pkg::*;
();

  logic       clk;
  logic       rst_n;
  cmd_word_t  cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       sclk;
  logic       cs;
  logic       mosi;
  logic       miso;
  logic       read_vld;
  read_byte_t read_data;
  int         frame_cnt;
  cmd_word_t  last_cmd;

  // stimulus side
  logic [31:0] lfsr = 32'h35f59bd0;
  read_byte_t  shadow [8];
  bit          written [8];
  read_byte_t  exp_bytes [$];
  string       exp_names [$];
  string       cur_test;
  int          test_errs0;
  int          accepted;
  int          tests_run;
  int          stim_checks;
  int          stim_errors;
  // compare side
  int          rd_idx;
  int          cmp_checks;
  int          cmp_errors;

  spi_cmd_master i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_periph_model i_periph (
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .frame_cnt (frame_cnt),
    .last_cmd  (last_cmd)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #4 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference and random source
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic read_byte_t ref_read(input reg_addr_t addr);
    if (written[addr])
      return shadow[addr];
    // power-up contents of the peripheral
    return ({5'd0, addr} * 8'h11) ^ 8'ha5;
  endfunction

  task automatic compare_byte(input string name, input read_byte_t exp, input read_byte_t act);
    cmp_checks++;
    if (act !== exp)
    begin
      cmp_errors++;
      $display("FAILED %s: expected 8'h%02h, got 8'h%02h", name, exp, act);
    end
  endtask

  task automatic compare_cmd(input string name, input cmd_word_t exp, input cmd_word_t act);
    stim_checks++;
    if (act !== exp)
    begin
      stim_errors++;
      $display("FAILED %s: expected 12'h%03h, got 12'h%03h", name, exp, act);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // command handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic start_cmd(input cmd_word_t word);
    reg_addr_t addr;
    addr = word[10:8];
    while (cmd_rdy !== 1'b1)
      @(negedge clk);
    cmd_in  = word;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    accepted++;
    if (word[CMD_WRITE_BIT])
    begin
      shadow[addr]  = word[7:0];
      written[addr] = 1'b1;
    end
    else
    begin
      exp_bytes.push_back(ref_read(addr));
      exp_names.push_back(cur_test);
    end
  endtask

  // cmd_rdy comes back only after ST_DONE
  task automatic wait_done();
    while (cmd_rdy !== 1'b1)
      @(negedge clk);
    if (rd_idx != exp_bytes.size())
    begin
      stim_errors++;
      $display("ERROR in %s: read command finished without read_vld", cur_test);
    end
  endtask

  task automatic issue_cmd(input cmd_word_t word);
    start_cmd(word);
    wait_done();
  endtask

  task automatic begin_test(input string name);
    cur_test   = name;
    test_errs0 = stim_errors + cmp_errors;
  endtask

  task automatic end_test();
    int errs;
    errs = stim_errors + cmp_errors - test_errs0;
    tests_run++;
    $display("test %0d %s finished with %0d errors", tests_run, cur_test, errs);
  endtask

  // every read_vld is matched against the oldest outstanding prediction
  always @(negedge clk)
  begin
    if (read_vld)
    begin
      if (rd_idx < exp_bytes.size())
      begin
        compare_byte(exp_names[rd_idx], exp_bytes[rd_idx], read_data);
        rd_idx++;
      end
      else
      begin
        cmp_errors++;
        $display("ERROR in %s: read_vld pulsed with no read outstanding", cur_test);
      end
    end
  end

  initial
  begin
    // reset-value reads, two directed tests, random ops, busy test
    repeat ((8 + 1 + 2 + 40 + 2) * 300 + 500)
      @(posedge clk);
    $display("ERROR: watchdog expired, the DUT stopped finishing commands");
    $display("sim failed");
    $finish;
  end

  initial
  begin
    cmd_word_t   word;
    logic [31:0] pick;
    reg_addr_t   addr;
    int          frames0;
    int          accepted0;

    rst_n   = 1'b0;
    cmd_vld = 1'b0;
    cmd_in  = '0;
    repeat (2)
      @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    begin_test("reset_state");
    @(negedge clk);
    stim_checks++;
    if (cmd_rdy !== 1'b1 || cs !== 1'b1 || sclk !== 1'b0 || mosi !== 1'b0)
    begin
      stim_errors++;
      $display("ERROR in %s: wrong idle outputs (cmd_rdy %b cs %b sclk %b mosi %b)",
               cur_test, cmd_rdy, cs, sclk, mosi);
    end
    repeat (20)
      @(negedge clk);
    end_test();

    begin_test("reset_values");
    for (int a = 0; a < 8; a++)
      issue_cmd({1'b0, reg_addr_t'(a), 8'h00});
    end_test();

    begin_test("write_frame");
    word = {1'b1, 3'd5, 8'hc3};
    issue_cmd(word);
    compare_cmd(cur_test, word, last_cmd);
    end_test();

    begin_test("write_then_read");
    issue_cmd({1'b1, 3'd2, 8'h5a});
    issue_cmd({1'b0, 3'd2, 8'h00});
    end_test();

    begin_test("random_ops");
    repeat (40)
    begin
      pick = take_bits(1);
      addr = reg_addr_t'(take_bits(3));
      if (pick[0])
        word = {1'b1, addr, read_byte_t'(take_bits(8))};
      else
        word = {1'b0, addr, 8'h00};
      issue_cmd(word);
      if (word[CMD_WRITE_BIT])
        compare_cmd(cur_test, word, last_cmd);
    end
    end_test();

    begin_test("busy_ignored");
    frames0   = frame_cnt;
    accepted0 = accepted;
    word      = {1'b1, 3'd6, 8'h3c};
    start_cmd(word);
    // stray read strobes while the write is on the wire
    repeat (4)
    begin
      repeat (6)
        @(negedge clk);
      cmd_in  = {1'b0, 3'd1, 8'h00};
      cmd_vld = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
      cmd_in  = word;
    end
    wait_done();
    compare_cmd(cur_test, word, last_cmd);
    issue_cmd({1'b0, 3'd6, 8'h00});
    stim_checks++;
    if (frame_cnt - frames0 != accepted - accepted0)
    begin
      stim_errors++;
      $display("FAILED %s: expected %0d frames, got %0d", cur_test,
               accepted - accepted0, frame_cnt - frames0);
    end
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests_run, stim_checks + cmp_checks,
             stim_errors + cmp_errors);
    if (stim_errors + cmp_errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// ==== spi_cmd_master.f ====
source/spi_cmd_pkg.sv
source/spi_sclk_gen.sv
source/spi_tx_shifter.sv
source/spi_rx_shifter.sv
source/spi_cmd_ctrl.sv
source/spi_cmd_master.sv
verification/spi_periph_model.sv
verification/spi_cmd_assertions.sv
verification/tb_spi_cmd_master.sv

// ==== Makefile ====
# Verilator build and run for the SPI command master testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_cmd_master
FILELIST  ?= spi_cmd_master.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= sim passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up as a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
